// File: logic/conv_pkg.sv
package conv_pkg;

	// unsigned input pixel.
	localparam int PIXEL_WIDTH = 8;

	// signed weight, the bias uses the same width.
	localparam int WEIGHT_WIDTH = 8;

	// signed pixel by weight product, pixel gets one zero bit on top.
	localparam int PRODUCT_WIDTH = PIXEL_WIDTH + 1 + WEIGHT_WIDTH;

	// signed window sum, room for a 5x5 window without overflow.
	localparam int ACC_WIDTH = 24;

	// unsigned result after relu and saturation.
	localparam int OUT_WIDTH = 8;

endpackage

// File: logic/pixel_scanner.sv
`timescale 1ns/1ps

module pixel_scanner #(
	parameter int IFM_SIZE = 8,
	parameter int KERNEL_SIZE = 5
) (
	input  logic clk,
	input  logic reset,
	input  logic pixel_valid,
	output logic window_valid,
	output logic [$clog2(IFM_SIZE)-1:0] win_row,
	output logic [$clog2(IFM_SIZE)-1:0] win_col
);
	localparam int POS_WIDTH = $clog2(IFM_SIZE);
	localparam logic [POS_WIDTH-1:0] LAST_POS = POS_WIDTH'(IFM_SIZE - 1);
	localparam logic [POS_WIDTH-1:0] WIN_OFFSET = POS_WIDTH'(KERNEL_SIZE - 1);

	logic [POS_WIDTH-1:0] row; // row of the next pixel.
	logic [POS_WIDTH-1:0] col; // column of the next pixel.
	logic row_end;
	logic window_done;

	assign row_end = (col == LAST_POS);
	// pixel closes a window lying fully inside the frame
	assign window_done = (row >= WIN_OFFSET) && (col >= WIN_OFFSET);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			row <= '0;
			col <= '0;
			window_valid <= 1'b0;
		end
		else
		begin
			window_valid <= pixel_valid && window_done;
			if (pixel_valid)
			begin
				if (row_end)
				begin
					col <= '0;
					row <= (row == LAST_POS) ? '0 : row + POS_WIDTH'(1); // wrap to next frame.
				end
				else
				begin
					col <= col + POS_WIDTH'(1);
				end
			end
		end
	end

	// top-left corner of the window.
	always_ff @(posedge clk)
	begin
		if (pixel_valid)
		begin
			win_row <= row - WIN_OFFSET;
			win_col <= col - WIN_OFFSET;
		end
	end

endmodule

// File: logic/window_buffer.sv
`timescale 1ns/1ps

module window_buffer #(
	parameter int IFM_SIZE = 8,
	parameter int KERNEL_SIZE = 5
) (
	input  logic clk,
	input  logic reset,
	input  logic shift_enable,
	input  logic [conv_pkg::PIXEL_WIDTH-1:0] pixel_in,
	output logic [KERNEL_SIZE*KERNEL_SIZE-1:0][conv_pkg::PIXEL_WIDTH-1:0] window
);
	import conv_pkg::*;

	// K-1 full lines plus K pixels of the current line
	localparam int BUF_SIZE = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;

	logic [PIXEL_WIDTH-1:0] buffer [BUF_SIZE];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int n = 0; n < BUF_SIZE; n++)
			begin
				buffer[n] <= '0;
			end
		end
		else if (shift_enable)
		begin
			buffer[0] <= pixel_in; // newest pixel.
			for (int n = 1; n < BUF_SIZE; n++)
			begin
				buffer[n] <= buffer[n - 1];
			end
		end
	end

	for (genvar i = 0; i < KERNEL_SIZE; i++)
	begin : g_row
		for (genvar j = 0; j < KERNEL_SIZE; j++)
		begin : g_col
			// row 0 is the oldest line, so it sits deepest in the buffer
			localparam int DEPTH = (KERNEL_SIZE - 1 - i) * IFM_SIZE + (KERNEL_SIZE - 1 - j);

			assign window[i * KERNEL_SIZE + j] = buffer[DEPTH];
		end
	end

endmodule

// File: logic/weight_store.sv
`timescale 1ns/1ps

module weight_store #(
	parameter int KERNEL_SIZE = 5
) (
	input  logic clk,
	input  logic reset,
	input  logic weight_load,
	input  logic signed [conv_pkg::WEIGHT_WIDTH-1:0] weight_data,
	output logic [KERNEL_SIZE*KERNEL_SIZE-1:0][conv_pkg::WEIGHT_WIDTH-1:0] kernel,
	output logic signed [conv_pkg::WEIGHT_WIDTH-1:0] bias
);
	import conv_pkg::*;

	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;

	logic [WEIGHT_WIDTH-1:0] chain [TAPS + 1];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int n = 0; n <= TAPS; n++)
			begin
				chain[n] <= '0;
			end
		end
		else if (weight_load)
		begin
			chain[0] <= weight_data;
			for (int n = 1; n <= TAPS; n++)
			begin
				chain[n] <= chain[n - 1];
			end
		end
	end

	assign bias = chain[0]; // last word written.

	// oldest word is w(0,0), then row by row.
	for (genvar t = 0; t < TAPS; t++)
	begin : g_tap
		assign kernel[t] = chain[TAPS - t];
	end

endmodule

// File: logic/mac_tree.sv
`timescale 1ns/1ps

module mac_tree #(
	parameter int KERNEL_SIZE = 5,
	parameter int POS_WIDTH = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic in_valid,
	input  logic [KERNEL_SIZE*KERNEL_SIZE-1:0][conv_pkg::PIXEL_WIDTH-1:0] window,
	input  logic [KERNEL_SIZE*KERNEL_SIZE-1:0][conv_pkg::WEIGHT_WIDTH-1:0] kernel,
	input  logic [POS_WIDTH-1:0] in_row,
	input  logic [POS_WIDTH-1:0] in_col,
	output logic sum_valid,
	output logic signed [conv_pkg::ACC_WIDTH-1:0] sum,
	output logic [POS_WIDTH-1:0] sum_row,
	output logic [POS_WIDTH-1:0] sum_col
);
	import conv_pkg::*;

	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;

	logic signed [PRODUCT_WIDTH-1:0] product [TAPS];
	logic prod_valid;
	logic [POS_WIDTH-1:0] prod_row;
	logic [POS_WIDTH-1:0] prod_col;

	// heap-ordered tree, node n adds nodes 2n+1 and 2n+2
	logic signed [ACC_WIDTH-1:0] node [2 * TAPS - 1];

	// stage one.
	always_ff @(posedge clk)
	begin
		for (int t = 0; t < TAPS; t++)
		begin
			product[t] <= PRODUCT_WIDTH'($signed({1'b0, window[t]}))
				* PRODUCT_WIDTH'($signed(kernel[t])); // pixel unsigned.
		end
		prod_row <= in_row;
		prod_col <= in_col;
	end

	always_comb
	begin
		for (int t = 0; t < TAPS; t++)
		begin
			node[TAPS - 1 + t] = ACC_WIDTH'(product[t]); // sign extend.
		end
		for (int n = TAPS - 2; n >= 0; n--)
		begin
			node[n] = node[2 * n + 1] + node[2 * n + 2];
		end
	end

	// stage two.
	always_ff @(posedge clk)
	begin
		sum <= node[0];
		sum_row <= prod_row;
		sum_col <= prod_col;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			prod_valid <= 1'b0;
			sum_valid <= 1'b0;
		end
		else
		begin
			prod_valid <= in_valid;
			sum_valid <= prod_valid;
		end
	end

endmodule

// File: logic/relu_output.sv
`timescale 1ns/1ps

module relu_output #(
	parameter int OUT_SHIFT = 4,
	parameter int POS_WIDTH = 3
) (
	input  logic clk,
	input  logic reset,
	input  logic sum_valid,
	input  logic signed [conv_pkg::ACC_WIDTH-1:0] sum,
	input  logic signed [conv_pkg::WEIGHT_WIDTH-1:0] bias,
	input  logic [POS_WIDTH-1:0] sum_row,
	input  logic [POS_WIDTH-1:0] sum_col,
	output logic result_valid,
	output logic [conv_pkg::OUT_WIDTH-1:0] result_data,
	output logic [POS_WIDTH-1:0] result_row,
	output logic [POS_WIDTH-1:0] result_col
);
	import conv_pkg::*;

	localparam logic signed [ACC_WIDTH-1:0] OUT_MAX = ACC_WIDTH'((1 << OUT_WIDTH) - 1);

	logic signed [ACC_WIDTH-1:0] biased;
	logic signed [ACC_WIDTH-1:0] shifted;
	logic [OUT_WIDTH-1:0] clamped;

	assign biased = sum + ACC_WIDTH'(bias); // bias sign extended.
	assign shifted = biased >>> OUT_SHIFT;

	always_comb
	begin
		if (shifted < 0)
			clamped = '0; // relu.
		else if (shifted > OUT_MAX)
			clamped = '1; // saturate.
		else
			clamped = shifted[OUT_WIDTH-1:0];
	end

	always_ff @(posedge clk)
	begin
		result_data <= clamped;
		result_row <= sum_row;
		result_col <= sum_col;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			result_valid <= 1'b0;
		else
			result_valid <= sum_valid;
	end

endmodule

// File: logic/conv_engine.sv
`timescale 1ns/1ps

module conv_engine #(
	parameter int IFM_SIZE = 8,
	parameter int KERNEL_SIZE = 5,
	parameter int OUT_SHIFT = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic pixel_valid,
	input  logic [conv_pkg::PIXEL_WIDTH-1:0] pixel_data,
	input  logic weight_load,
	input  logic signed [conv_pkg::WEIGHT_WIDTH-1:0] weight_data,
	output logic result_valid,
	output logic [conv_pkg::OUT_WIDTH-1:0] result_data,
	output logic [$clog2(IFM_SIZE)-1:0] result_row,
	output logic [$clog2(IFM_SIZE)-1:0] result_col
);
	import conv_pkg::*;

	localparam int POS_WIDTH = $clog2(IFM_SIZE);
	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;

	logic window_valid;
	logic [POS_WIDTH-1:0] win_row;
	logic [POS_WIDTH-1:0] win_col;
	logic [TAPS-1:0][PIXEL_WIDTH-1:0] window;
	logic [TAPS-1:0][WEIGHT_WIDTH-1:0] kernel;
	logic signed [WEIGHT_WIDTH-1:0] bias;
	logic sum_valid;
	logic signed [ACC_WIDTH-1:0] sum;
	logic [POS_WIDTH-1:0] sum_row;
	logic [POS_WIDTH-1:0] sum_col;

	pixel_scanner #(.IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE)) scanner (
		.clk(clk), .reset(reset), .pixel_valid(pixel_valid),
		.window_valid(window_valid), .win_row(win_row), .win_col(win_col)
	);

	window_buffer #(.IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE)) buffer (
		.clk(clk), .reset(reset), .shift_enable(pixel_valid),
		.pixel_in(pixel_data), .window(window)
	);

	weight_store #(.KERNEL_SIZE(KERNEL_SIZE)) weights (
		.clk(clk), .reset(reset), .weight_load(weight_load),
		.weight_data(weight_data), .kernel(kernel), .bias(bias)
	);

	mac_tree #(.KERNEL_SIZE(KERNEL_SIZE), .POS_WIDTH(POS_WIDTH)) mac (
		.clk(clk), .reset(reset), .in_valid(window_valid),
		.window(window), .kernel(kernel), .in_row(win_row), .in_col(win_col),
		.sum_valid(sum_valid), .sum(sum), .sum_row(sum_row), .sum_col(sum_col)
	);

	relu_output #(.OUT_SHIFT(OUT_SHIFT), .POS_WIDTH(POS_WIDTH)) relu (
		.clk(clk), .reset(reset), .sum_valid(sum_valid), .sum(sum), .bias(bias),
		.sum_row(sum_row), .sum_col(sum_col),
		.result_valid(result_valid), .result_data(result_data),
		.result_row(result_row), .result_col(result_col)
	);

endmodule

// File: tb/conv_engine_checker.sv
`timescale 1ns/1ps

module conv_engine_checker (
	input  logic clk,
	input  logic reset,
	input  logic window_valid,
	input  logic result_valid,
	input  logic [conv_pkg::OUT_WIDTH-1:0] result_data
);

	quiet_in_reset: assert property (@(posedge clk) reset |-> !result_valid)
		else $error("result_valid high while reset is asserted");

	// window to result is three register stages.
	result_has_window: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> $past(window_valid, 3))
		else $error("result_valid without a valid window three cycles earlier");

	result_known: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> !$isunknown(result_data))
		else $error("result_data unknown while result_valid is high");

endmodule

bind conv_engine conv_engine_checker timing_check (
	.clk(clk),
	.reset(reset),
	.window_valid(window_valid),
	.result_valid(result_valid),
	.result_data(result_data)
);

// File: tb/conv_engine_tb.sv
`timescale 1ns/1ps

module conv_engine_tb;
	import conv_pkg::*;

	localparam int IFM_SIZE = 8;
	localparam int KERNEL_SIZE = 5;
	localparam int OUT_SHIFT = 4;
	localparam int TAPS = KERNEL_SIZE * KERNEL_SIZE;
	localparam int OUT_SIDE = IFM_SIZE - KERNEL_SIZE + 1;
	localparam int POS_WIDTH = $clog2(IFM_SIZE);
	localparam int LATENCY = 4; // accept edge to the edge that sees the strobe.
	localparam int DRAIN_LIMIT = 50;
	localparam int NUM_TESTS = 8;

	typedef enum logic [1:0] {
		KERNEL_IDENTITY, KERNEL_ONES, KERNEL_RANDOM, KERNEL_NEGATIVE
	} kernel_kind_t;
	typedef enum logic [1:0] {IMAGE_CONSTANT, IMAGE_RAMP, IMAGE_RANDOM} image_kind_t;

	typedef struct packed {
		kernel_kind_t kernel_kind;
		int bias;
		image_kind_t image_kind;
		int pixel_value;
		bit gaps;
		int frames;
		int expected; // -1 when only the model knows the value.
	} test_row_t;

	typedef struct packed {
		int row;
		int col;
		int value;
		int accept;
	} expect_t;

	localparam test_row_t TESTS [NUM_TESTS] = '{
		'{KERNEL_IDENTITY, 0, IMAGE_CONSTANT, 200, 1'b0, 1, 12},
		'{KERNEL_IDENTITY, 0, IMAGE_RAMP, 0, 1'b0, 1, -1},
		'{KERNEL_ONES, 20, IMAGE_CONSTANT, 100, 1'b0, 1, 157},
		'{KERNEL_ONES, 0, IMAGE_CONSTANT, 200, 1'b1, 1, 255},
		'{KERNEL_NEGATIVE, -20, IMAGE_RANDOM, 0, 1'b0, 1, 0},
		'{KERNEL_RANDOM, 7, IMAGE_RANDOM, 0, 1'b0, 1, -1},
		'{KERNEL_RANDOM, -3, IMAGE_RANDOM, 0, 1'b1, 1, -1},
		'{KERNEL_RANDOM, 50, IMAGE_RANDOM, 0, 1'b0, 2, -1}
	};

	logic clk;
	logic reset;
	logic pixel_valid;
	logic [PIXEL_WIDTH-1:0] pixel_data;
	logic weight_load;
	logic signed [WEIGHT_WIDTH-1:0] weight_data;
	logic result_valid;
	logic [OUT_WIDTH-1:0] result_data;
	logic [POS_WIDTH-1:0] result_row;
	logic [POS_WIDTH-1:0] result_col;

	int kernel [TAPS];
	int image [IFM_SIZE][IFM_SIZE];
	expect_t expected_q [$];
	int cycle = 0;
	int checks = 0;
	int errors = 0;
	int test_results;
	int test_errors;
	bit timed_out = 1'b0;

	conv_engine #(.IFM_SIZE(IFM_SIZE), .KERNEL_SIZE(KERNEL_SIZE), .OUT_SHIFT(OUT_SHIFT)) uut (
		.clk(clk), .reset(reset), .pixel_valid(pixel_valid), .pixel_data(pixel_data),
		.weight_load(weight_load), .weight_data(weight_data),
		.result_valid(result_valid), .result_data(result_data),
		.result_row(result_row), .result_col(result_col)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic void note_error();
		errors++;
		test_errors++;
	endfunction

	// model of one window, straight from the result rule
	function automatic int window_result(int r0, int c0, int bias);
		int sum;
		sum = bias;
		for (int i = 0; i < KERNEL_SIZE; i++)
		begin
			for (int j = 0; j < KERNEL_SIZE; j++)
			begin
				sum += image[r0 + i][c0 + j] * kernel[i * KERNEL_SIZE + j];
			end
		end
		sum = sum >>> OUT_SHIFT;
		if (sum < 0)
			return 0;
		if (sum > (1 << OUT_WIDTH) - 1)
			return (1 << OUT_WIDTH) - 1;
		return sum;
	endfunction

	task automatic fill_kernel(kernel_kind_t kind);
		for (int t = 0; t < TAPS; t++)
		begin
			case (kind)
				KERNEL_IDENTITY: kernel[t] = (t == TAPS / 2) ? 1 : 0; // centre tap.
				KERNEL_ONES: kernel[t] = 1;
				KERNEL_NEGATIVE: kernel[t] = -int'($urandom_range(8, 1));
				default: kernel[t] = int'($urandom_range(15, 0)) - 8;
			endcase
		end
	endtask

	task automatic fill_image(test_row_t cfg, int frame);
		for (int r = 0; r < IFM_SIZE; r++)
		begin
			for (int c = 0; c < IFM_SIZE; c++)
			begin
				case (cfg.image_kind)
					IMAGE_CONSTANT: image[r][c] = cfg.pixel_value;
					IMAGE_RAMP: image[r][c] = ((r * IFM_SIZE + c) * 4 + frame) % 256;
					default: image[r][c] = int'($urandom_range(255, 0));
				endcase
			end
		end
	endtask

	// oldest word is w(0,0), the bias goes last.
	task automatic load_weights(int bias);
		for (int t = 0; t <= TAPS; t++)
		begin
			@(posedge clk);
			weight_load <= 1'b1;
			weight_data <= (t < TAPS) ? WEIGHT_WIDTH'(kernel[t]) : WEIGHT_WIDTH'(bias);
		end
		@(posedge clk);
		weight_load <= 1'b0;
	endtask

	task automatic stream_frame(test_row_t cfg);
		expect_t entry;
		for (int r = 0; r < IFM_SIZE; r++)
		begin
			for (int c = 0; c < IFM_SIZE; c++)
			begin
				if (cfg.gaps && $urandom_range(2, 0) == 0)
				begin
					@(posedge clk);
					pixel_valid <= 1'b0; // idle cycle.
				end
				@(posedge clk);
				pixel_valid <= 1'b1;
				pixel_data <= PIXEL_WIDTH'(image[r][c]);
				if (r >= KERNEL_SIZE - 1 && c >= KERNEL_SIZE - 1)
				begin
					entry.row = r - KERNEL_SIZE + 1;
					entry.col = c - KERNEL_SIZE + 1;
					entry.value = (cfg.expected >= 0) ? cfg.expected :
						window_result(entry.row, entry.col, cfg.bias);
					entry.accept = cycle + 1; // sampled at the next edge.
					expected_q.push_back(entry);
				end
			end
		end
	endtask

	task automatic wait_for_results(int t);
		int waited;
		waited = 0;
		while (expected_q.size() > 0 && waited < DRAIN_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (expected_q.size() > 0)
		begin
			$display("timeout: test %0d still waits for %0d results after %0d cycles",
				t, expected_q.size(), DRAIN_LIMIT);
			note_error();
			timed_out = 1'b1;
		end
		repeat (LATENCY + 2) @(negedge clk); // catch stray strobes.
	endtask

	always @(posedge clk)
	begin : monitor
		expect_t entry;
		if (result_valid)
		begin
			checks++;
			assert (expected_q.size() > 0)
			else
			begin
				$display("result at time %0t arrived with no window waiting for it", $time);
				note_error();
			end
			if (expected_q.size() > 0)
			begin
				entry = expected_q.pop_front();
				test_results++;
				assert (int'(result_data) == entry.value)
				else
				begin
					$display("MISMATCH at %0t: window (%0d,%0d) gave %0d, expected %0d",
						$time, entry.row, entry.col, result_data, entry.value);
					note_error();
				end
				assert (int'(result_row) == entry.row && int'(result_col) == entry.col)
				else
				begin
					$display("MISMATCH at %0t: position (%0d,%0d), expected (%0d,%0d)",
						$time, result_row, result_col, entry.row, entry.col);
					note_error();
				end
				assert (cycle == entry.accept + LATENCY)
				else
				begin
					$display("MISMATCH at %0t: result %0d cycles after its pixel, expected %0d",
						$time, cycle - entry.accept, LATENCY);
					note_error();
				end
			end
		end
	end

	initial
	begin
		void'($urandom(32'h05a8_f6e8));
		reset = 1'b1;
		pixel_valid = 1'b0;
		pixel_data = '0;
		weight_load = 1'b0;
		weight_data = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int t = 0; t < NUM_TESTS && !timed_out; t++)
		begin
			test_results = 0;
			test_errors = 0;
			fill_kernel(TESTS[t].kernel_kind);
			load_weights(TESTS[t].bias);
			for (int f = 0; f < TESTS[t].frames; f++)
			begin
				fill_image(TESTS[t], f);
				stream_frame(TESTS[t]);
			end
			@(posedge clk);
			pixel_valid <= 1'b0;
			wait_for_results(t);
			checks++;
			assert (test_results == TESTS[t].frames * OUT_SIDE * OUT_SIDE)
			else
			begin
				$display("MISMATCH at %0t: test %0d got %0d results, expected %0d",
					$time, t, test_results, TESTS[t].frames * OUT_SIDE * OUT_SIDE);
				note_error();
			end
			$display("test %0d: %0d results, %0d errors", t, test_results, test_errors);
		end
		$display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: tb.f
logic/conv_pkg.sv
logic/pixel_scanner.sv
logic/window_buffer.sv
logic/weight_store.sv
logic/mac_tree.sv
logic/relu_output.sv
logic/conv_engine.sv
tb/conv_engine_checker.sv
tb/conv_engine_tb.sv

// File: Makefile
TOP = conv_engine_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build output"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep "ALL CHECKS PASSED" > /dev/null

clean:
	rm -rf obj_dir
